//--- compile.f
+incdir+verilog
verilog/video_stream_pkg.sv
verilog/reset_counter.sv
verilog/upl_fifo.sv
verilog/line_packer.sv
verilog/upl_sender.sv
verilog/video_stream_top.sv
testbench/video_stream_sva.sv
testbench/tb_video_stream.sv

//--- testbench/tb_video_stream.sv
`timescale 1ns/1ps
`default_nettype none

`include "video_stream_macros.svh"

module tb_video_stream;

    import video_stream_pkg::*;

    localparam logic [31:0] SEED = 32'h7ffd0fd2;
    // about 40 lines of up to 80 cycles each, plus ack stalls and drains
    localparam int MAX_CYCLES = 4000;

    logic           clk;
    logic           rst_n_i;
    logic           vid_de_i;
    logic           vid_vsync_i;
    pixel_t         vid_data_i;
    logic           upl_ack_i;
    wire            upl_req_o;
    wire            upl_en_o;
    wire upl_word_u upl_data_o;
    wire            ready_o;
    wire [15:0]     drop_count_o;

    // reference model
    upl_word_u   exp_words[$];
    int          exp_len[$];
    int          pending_words;
    logic [7:0]  frame_num;
    logic [15:0] line_num;

    // output monitor
    logic        in_pkt;
    int          remaining;
    int          pkt_count;
    upl_word_u   mon_exp;

    string       test_name;
    logic [31:0] stim_state;
    logic [31:0] ack_state;
    logic        hold_ack;
    logic        random_ack;
    int          ack_delay;
    int          ack_wait;
    int          cycle_count;

    video_stream_top i_dut (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .vid_de_i     (vid_de_i),
        .vid_vsync_i  (vid_vsync_i),
        .vid_data_i   (vid_data_i),
        .upl_ack_i    (upl_ack_i),
        .upl_req_o    (upl_req_o),
        .upl_en_o     (upl_en_o),
        .upl_data_o   (upl_data_o),
        .ready_o      (ready_o),
        .drop_count_o (drop_count_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic pixel_t next_pixel();
        stim_state = lcg_next(stim_state);
        return stim_state[31:8];
    endfunction

    function automatic int rand_below(input int n);
        stim_state = lcg_next(stim_state);
        return int'(stim_state[31:16]) % n;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            fail_run($sformatf("error: %s %s expected 0x%0h actual 0x%0h",
                               test_name, what, exp, act));
        end
    endtask

    // drives one active line and gap cycles of blanking while updating the model
    task automatic drive_line(input int len, input int gap);
        logic [7:0] bytes[$];
        upl_word_u  w;
        logic       accept;
        int         in_fifo;
        int         i;
        accept = 1'b0;
        for (i = 0; i < len; i++) begin
            @(negedge clk);
            if (i == 0) begin
                // the sender holds one record and the others wait in the control FIFO
                in_fifo = (exp_len.size() > 0) ? exp_len.size() - 1 : 0;
                accept  = (in_fifo < `CTRL_FIFO_DEPTH) &&
                          (`DATA_FIFO_DEPTH - pending_words >= `MAX_LINE_WORDS);
            end
            vid_de_i   = 1'b1;
            vid_data_i = next_pixel();
            bytes.push_back(vid_data_i[7:0]);
            bytes.push_back(vid_data_i[15:8]);
            bytes.push_back(vid_data_i[23:16]);
        end
        @(negedge clk);
        vid_de_i   = 1'b0;
        vid_data_i = '0;
        if (accept) begin
            while (bytes.size() % 4 != 0) begin
                bytes.push_back(8'h00);
            end
            w.hdr.magic = `HDR_MAGIC;
            w.hdr.frame = frame_num;
            w.hdr.line  = line_num;
            exp_words.push_back(w);
            // byte 0 of the line lands in bits 7:0 of the first word
            for (i = 0; i < bytes.size(); i += 4) begin
                w.raw = {bytes[i+3], bytes[i+2], bytes[i+1], bytes[i]};
                exp_words.push_back(w);
            end
            exp_len.push_back(bytes.size() / 4);
            pending_words += bytes.size() / 4;
        end
        line_num++;
        repeat (gap - 1) @(negedge clk);
    endtask

    task automatic pulse_vsync();
        @(negedge clk);
        vid_vsync_i = 1'b1;
        frame_num++;
        line_num = 16'd0;
        repeat (3) @(negedge clk);
        vid_vsync_i = 1'b0;
        repeat (2) @(negedge clk);
    endtask

    task automatic wait_drained();
        while (exp_len.size() != 0 || in_pkt || upl_req_o) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
    endtask

    // the receiver answers each request after ack_delay cycles
    always @(negedge clk) begin
        if (upl_ack_i) begin
            upl_ack_i = 1'b0;
            ack_wait  = 0;
            if (random_ack) begin
                ack_state = lcg_next(ack_state);
                ack_delay = int'(ack_state[31:16]) % 21;
            end else begin
                ack_delay = 2;
            end
        end else if (upl_req_o && !hold_ack) begin
            if (ack_wait >= ack_delay) begin
                upl_ack_i = 1'b1;
            end else begin
                ack_wait++;
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n_i && upl_en_o && !in_pkt) begin
            if (exp_len.size() == 0) begin
                fail_run("a UPL packet arrived while no line was waiting to be sent");
            end else begin
                mon_exp   = exp_words.pop_front();
                remaining = exp_len.pop_front();
                in_pkt    = 1'b1;
                pkt_count++;
                check_eq("header magic", mon_exp.hdr.magic, upl_data_o.hdr.magic);
                check_eq("header frame", mon_exp.hdr.frame, upl_data_o.hdr.frame);
                check_eq("header line", mon_exp.hdr.line, upl_data_o.hdr.line);
            end
        end else if (rst_n_i && upl_en_o) begin
            if (remaining == 0) begin
                fail_run("a UPL packet carried more payload words than its line");
            end else begin
                mon_exp = exp_words.pop_front();
                remaining--;
                pending_words--;
                check_eq("payload word", mon_exp.raw, upl_data_o.raw);
            end
        end else if (in_pkt) begin
            check_eq("payload words missing at end of packet", 0, remaining);
            in_pkt = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > MAX_CYCLES) begin
            fail_run($sformatf("timeout: run did not finish within %0d cycles", MAX_CYCLES));
        end
    end

    always @(negedge clk) begin
        if (i_dut.i_sva.err_count != 0) begin
            fail_run("a UPL protocol assertion failed");
        end
    end

    initial begin
        int edges;
        int first_pkt;
        rst_n_i       = 1'b0;
        vid_de_i      = 1'b0;
        vid_vsync_i   = 1'b0;
        vid_data_i    = '0;
        upl_ack_i     = 1'b0;
        stim_state    = SEED;
        ack_state     = SEED;
        hold_ack      = 1'b0;
        random_ack    = 1'b0;
        ack_delay     = 2;
        ack_wait      = 0;
        cycle_count   = 0;
        pending_words = 0;
        frame_num     = 8'd0;
        line_num      = 16'd0;
        in_pkt        = 1'b0;
        remaining     = 0;
        pkt_count     = 0;

        test_name = "reset_hold";
        repeat (8) begin
            @(negedge clk);
            check_eq("ready_o in reset", 0, ready_o);
            check_eq("upl_en_o in reset", 0, upl_en_o);
            check_eq("drop_count_o in reset", 0, drop_count_o);
        end
        rst_n_i = 1'b1;
        edges   = 0;
        do begin
            @(negedge clk);
            edges++;
            check_eq("upl_req_o before ready", 0, upl_req_o);
        end while (!ready_o && edges <= 2 * `RESET_HOLD);
        check_eq("cycles from first edge to ready_o", `RESET_HOLD, edges - 1);

        // 16, 15 and 5 pixels make 12, 12 and 4 words
        test_name = "packing";
        drive_line(16, 8);
        drive_line(15, 8);
        drive_line(5, 8);
        wait_drained();

        test_name = "numbering";
        pulse_vsync();
        drive_line(10, 8);
        drive_line(12, 8);
        drive_line(8, 8);
        pulse_vsync();
        drive_line(7, 8);
        drive_line(9, 8);
        wait_drained();

        test_name  = "slow_ack";
        random_ack = 1'b1;
        repeat (12) begin
            drive_line(1 + rand_below(32), 24);
        end
        wait_drained();
        random_ack = 1'b0;

        // the sender keeps one record and the control FIFO the next four
        test_name = "back_pressure";
        hold_ack  = 1'b1;
        first_pkt = pkt_count;
        repeat (8) drive_line(16, 6);
        hold_ack = 1'b0;
        wait_drained();
        check_eq("lines delivered", `CTRL_FIFO_DEPTH + 1, pkt_count - first_pkt);
        check_eq("drop_count_o", 8 - (`CTRL_FIFO_DEPTH + 1), drop_count_o);

        // the header of a line after the drops shows that they were numbered
        drive_line(16, 6);
        wait_drained();

        if (i_dut.i_sva.err_count == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            fail_run("a UPL protocol assertion failed");
        end
    end

endmodule

`default_nettype wire

//--- testbench/video_stream_sva.sv
`timescale 1ns/1ps
`default_nettype none

`include "video_stream_macros.svh"

module video_stream_sva (
    input wire                                  clk,
    input wire                                  rst_n_i,
    input wire                                  req_i,
    input wire                                  ack_i,
    input wire                                  en_i,
    input wire video_stream_pkg::upl_word_u     data_i,
    input wire                                  ready_i
);

    // read by the testbench to end the run
    int unsigned err_count = 0;

    // a packet only starts after an acknowledged request
    en_after_ack: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(en_i) |-> $past(req_i && ack_i))
        else begin $error("upl_en_o rose without req and ack"); err_count++; end

    req_held: assert property (@(posedge clk) disable iff (!rst_n_i)
        (req_i && !ack_i) |=> req_i)
        else begin $error("upl_req_o dropped before ack"); err_count++; end

    req_en_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(req_i && en_i))
        else begin $error("upl_req_o and upl_en_o high together"); err_count++; end

    // first word of every packet is the header
    hdr_magic: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(en_i) |-> (data_i.hdr.magic == `HDR_MAGIC))
        else begin $error("first packet word lacks the header magic"); err_count++; end

    no_req_in_reset: assert property (@(posedge clk) disable iff (!rst_n_i)
        !ready_i |-> !req_i)
        else begin $error("upl_req_o high while ready_o is low"); err_count++; end

endmodule

bind video_stream_top video_stream_sva i_sva (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .req_i   (upl_req_o),
    .ack_i   (upl_ack_i),
    .en_i    (upl_en_o),
    .data_i  (upl_data_o),
    .ready_i (ready_o)
);

`default_nettype wire

//--- verilog/line_packer.sv
`timescale 1ns/1ps
`default_nettype none

`include "video_stream_macros.svh"

module line_packer (
    input  wire                                     clk,
    input  wire                                     rst_n_i,
    input  wire                                     core_rst_i,
    input  wire                                     vid_de_i,
    input  wire                                     vid_vsync_i,
    input  wire video_stream_pkg::pixel_t           vid_data_i,
    input  wire [$clog2(`DATA_FIFO_DEPTH+1)-1:0]    data_free_i,
    input  wire                                     ctrl_full_i,
    output logic                                    data_wr_o,
    output logic [`UPL_WIDTH-1:0]                   data_word_o,
    output logic                                    ctrl_wr_o,
    output video_stream_pkg::line_info_t            ctrl_info_o,
    output logic [15:0]                             drop_count_o
);

    import video_stream_pkg::*;

    logic        de_q;
    logic        vsync_q;
    logic        accept_q;
    logic [1:0]  phase_q;
    logic [11:0] words_q;
    logic [7:0]  frame_q;
    logic [15:0] line_q;
    pixel_t      acc_q;

    logic        line_start;
    logic        line_end;
    logic        frame_start;
    logic        accept_now;
    logic        take_pixel;
    logic [1:0]  phase_cur;
    logic [11:0] words_cur;

    assign line_start  = vid_de_i && !de_q;
    assign line_end    = !vid_de_i && de_q;
    assign frame_start = vid_vsync_i && !vsync_q;

    // each line is judged once on room for a full-length line and one more record
    assign accept_now = line_start ? (!ctrl_full_i && (data_free_i >= `MAX_LINE_WORDS))
                                   : accept_q;
    assign take_pixel = vid_de_i && accept_now;

    // packing position restarts with every line
    assign phase_cur = line_start ? 2'd0 : phase_q;
    assign words_cur = line_start ? 12'd0 : words_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            de_q         <= 1'b0;
            vsync_q      <= 1'b0;
            accept_q     <= 1'b0;
            phase_q      <= 2'd0;
            words_q      <= 12'd0;
            frame_q      <= 8'd0;
            line_q       <= 16'd0;
            data_wr_o    <= 1'b0;
            ctrl_wr_o    <= 1'b0;
            drop_count_o <= 16'd0;
        end else if (core_rst_i) begin
            de_q         <= 1'b0;
            vsync_q      <= 1'b0;
            accept_q     <= 1'b0;
            phase_q      <= 2'd0;
            words_q      <= 12'd0;
            frame_q      <= 8'd0;
            line_q       <= 16'd0;
            data_wr_o    <= 1'b0;
            ctrl_wr_o    <= 1'b0;
            drop_count_o <= 16'd0;
        end else begin
            de_q      <= vid_de_i;
            vsync_q   <= vid_vsync_i;
            data_wr_o <= 1'b0;
            ctrl_wr_o <= 1'b0;

            if (line_start) begin
                accept_q <= accept_now;
                if (!accept_now) begin
                    drop_count_o <= drop_count_o + 16'd1;
                end
            end

            // a word completes on every pixel except the first of each group of four
            if (take_pixel) begin
                phase_q <= phase_cur + 2'd1;
                words_q <= words_cur + 12'(phase_cur != 2'd0);
                if (phase_cur != 2'd0) begin
                    data_wr_o <= 1'b1;
                end
            end

            // dropped lines still count
            if (line_end) begin
                line_q <= line_q + 16'd1;
                if (accept_q) begin
                    ctrl_wr_o <= 1'b1;
                    if (phase_q != 2'd0) begin
                        data_wr_o <= 1'b1;
                    end
                end
            end

            if (frame_start) begin
                frame_q <= frame_q + 8'd1;
                line_q  <= 16'd0;
            end
        end
    end

    // little-endian byte packing with leftover bytes kept zero-extended in acc_q
    always_ff @(posedge clk) begin
        if (take_pixel) begin
            case (phase_cur)
                2'd0: begin
                    acc_q <= vid_data_i;
                end
                2'd1: begin
                    data_word_o <= {vid_data_i[7:0], acc_q};
                    acc_q       <= {8'h00, vid_data_i[23:8]};
                end
                2'd2: begin
                    data_word_o <= {vid_data_i[15:0], acc_q[15:0]};
                    acc_q       <= {16'h0000, vid_data_i[23:16]};
                end
                default: begin
                    data_word_o <= {vid_data_i, acc_q[7:0]};
                end
            endcase
        end else if (line_end) begin
            // the padded tail word is only written when phase_q is nonzero
            data_word_o       <= {8'h00, acc_q};
            ctrl_info_o.frame <= frame_q;
            ctrl_info_o.line  <= line_q;
            ctrl_info_o.words <= words_q + 12'(phase_q != 2'd0);
        end
    end

endmodule

`default_nettype wire

//--- verilog/reset_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "video_stream_macros.svh"

module reset_counter (
    input  wire  clk,
    input  wire  rst_n_i,
    output logic core_rst_o,
    output logic ready_o
);

    localparam int CNT_W = $clog2(`RESET_HOLD + 1);

    logic [CNT_W-1:0] cnt_q;
    logic             holding;

    // still counting towards the hold limit
    assign holding = (cnt_q != CNT_W'(`RESET_HOLD));

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q      <= '0;
            core_rst_o <= 1'b1;
            ready_o    <= 1'b0;
        end else begin
            // counter saturates at the limit
            if (holding) begin
                cnt_q <= cnt_q + 1'b1;
            end
            core_rst_o <= holding;
            ready_o    <= !holding;
        end
    end

endmodule

`default_nettype wire

//--- verilog/upl_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module upl_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 16
) (
    input  wire                         clk,
    input  wire                         rst_n_i,
    input  wire                         sync_rst_i,
    input  wire                         wr_i,
    input  wire  [WIDTH-1:0]            wr_data_i,
    input  wire                         rd_i,
    output logic [WIDTH-1:0]            rd_data_o,
    output logic                        empty_o,
    output logic                        full_o,
    output logic [$clog2(DEPTH+1)-1:0]  free_o
);

    localparam int AW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr_q;
    logic [AW-1:0]    rd_ptr_q;
    logic [CW-1:0]    count_q;
    logic             push;
    logic             pop;

    // writes when full and reads when empty are ignored
    assign push = wr_i && !full_o;
    assign pop  = rd_i && !empty_o;

    assign empty_o = (count_q == '0);
    assign full_o  = (count_q == CW'(DEPTH));
    assign free_o  = CW'(DEPTH) - count_q;

    // show-ahead, head is valid whenever not empty
    assign rd_data_o = mem[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr_q] <= wr_data_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (sync_rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == AW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == AW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + CW'(push) - CW'(pop);
        end
    end

endmodule

`default_nettype wire

//--- verilog/upl_sender.sv
`timescale 1ns/1ps
`default_nettype none

`include "video_stream_macros.svh"

module upl_sender (
    input  wire                                 clk,
    input  wire                                 rst_n_i,
    input  wire                                 core_rst_i,
    input  wire                                 ctrl_empty_i,
    input  wire video_stream_pkg::line_info_t   ctrl_info_i,
    input  wire [`UPL_WIDTH-1:0]                data_word_i,
    input  wire                                 upl_ack_i,
    output logic                                ctrl_rd_o,
    output logic                                data_rd_o,
    output logic                                upl_req_o,
    output logic                                upl_en_o,
    output video_stream_pkg::upl_word_u         upl_data_o
);

    import video_stream_pkg::*;

    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_REQ    = 2'd1;
    localparam logic [1:0] ST_STREAM = 2'd2;

    logic [1:0]  state_q;
    logic [11:0] cnt_q;
    line_info_t  info_q;

    // record is popped as soon as the sender is free
    assign ctrl_rd_o = (state_q == ST_IDLE) && !ctrl_empty_i;

    // payload is already in the data FIFO when its record is visible
    assign data_rd_o = (state_q == ST_STREAM) && (cnt_q != 12'd0);

    assign upl_req_o = (state_q == ST_REQ);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q  <= ST_IDLE;
            cnt_q    <= 12'd0;
            upl_en_o <= 1'b0;
        end else if (core_rst_i) begin
            state_q  <= ST_IDLE;
            cnt_q    <= 12'd0;
            upl_en_o <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (!ctrl_empty_i) begin
                        state_q <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    // header goes out the cycle after ack
                    if (upl_ack_i) begin
                        state_q  <= ST_STREAM;
                        upl_en_o <= 1'b1;
                        cnt_q    <= info_q.words;
                    end
                end
                ST_STREAM: begin
                    if (cnt_q == 12'd0) begin
                        state_q  <= ST_IDLE;
                        upl_en_o <= 1'b0;
                    end else begin
                        cnt_q <= cnt_q - 12'd1;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl_rd_o) begin
            info_q <= ctrl_info_i;
        end
        // header stays loaded while waiting for ack
        if (state_q == ST_REQ) begin
            upl_data_o.hdr.magic <= `HDR_MAGIC;
            upl_data_o.hdr.frame <= info_q.frame;
            upl_data_o.hdr.line  <= info_q.line;
        end else if (data_rd_o) begin
            upl_data_o.raw <= data_word_i;
        end
    end

endmodule

`default_nettype wire

//--- verilog/video_stream_macros.svh
`ifndef VIDEO_STREAM_MACROS_SVH
`define VIDEO_STREAM_MACROS_SVH

// cycles the core stays in reset after rst_n_i is released
`define RESET_HOLD 16

// UPL data word and RGB pixel widths
`define UPL_WIDTH 32
`define PIXEL_WIDTH 24

// longest line the packer accepts, 64 pixels
`define MAX_LINE_WORDS 48

// FIFO depths for payload words and line records
`define DATA_FIFO_DEPTH 256
`define CTRL_FIFO_DEPTH 4

// top byte of every header word
`define HDR_MAGIC 8'hA5

`endif

//--- verilog/video_stream_pkg.sv
`default_nettype none

`include "video_stream_macros.svh"

package video_stream_pkg;

    // one RGB pixel as delivered by the video source
    typedef logic [`PIXEL_WIDTH-1:0] pixel_t;

    // per-line record passed from the packer to the sender
    typedef struct packed {
        logic [7:0]  frame;
        logic [15:0] line;
        logic [11:0] words;
    } line_info_t;

    // header layout, magic in the top byte
    typedef struct packed {
        logic [7:0]  magic;
        logic [7:0]  frame;
        logic [15:0] line;
    } upl_hdr_t;

    // a UPL word is either a header or plain payload
    typedef union packed {
        upl_hdr_t               hdr;
        logic [`UPL_WIDTH-1:0]  raw;
    } upl_word_u;

endpackage

`default_nettype wire

//--- verilog/video_stream_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "video_stream_macros.svh"

module video_stream_top (
    input  wire                                 clk,
    input  wire                                 rst_n_i,
    input  wire                                 vid_de_i,
    input  wire                                 vid_vsync_i,
    input  wire video_stream_pkg::pixel_t       vid_data_i,
    input  wire                                 upl_ack_i,
    output wire                                 upl_req_o,
    output wire                                 upl_en_o,
    output wire video_stream_pkg::upl_word_u    upl_data_o,
    output wire                                 ready_o,
    output wire [15:0]                          drop_count_o
);

    import video_stream_pkg::*;

    wire                                    core_rst;

    // payload path
    wire                                    data_wr;
    wire [`UPL_WIDTH-1:0]                   data_word;
    wire                                    data_rd;
    wire [`UPL_WIDTH-1:0]                   data_head;
    wire [$clog2(`DATA_FIFO_DEPTH+1)-1:0]   data_free;

    // line records
    wire                                    ctrl_wr;
    wire line_info_t                        ctrl_info;
    wire                                    ctrl_rd;
    wire line_info_t                        ctrl_head;
    wire                                    ctrl_empty;
    wire                                    ctrl_full;

    reset_counter i_reset (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .core_rst_o (core_rst),
        .ready_o    (ready_o)
    );

    line_packer i_packer (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .core_rst_i   (core_rst),
        .vid_de_i     (vid_de_i),
        .vid_vsync_i  (vid_vsync_i),
        .vid_data_i   (vid_data_i),
        .data_free_i  (data_free),
        .ctrl_full_i  (ctrl_full),
        .data_wr_o    (data_wr),
        .data_word_o  (data_word),
        .ctrl_wr_o    (ctrl_wr),
        .ctrl_info_o  (ctrl_info),
        .drop_count_o (drop_count_o)
    );

    upl_fifo #(
        .WIDTH (`UPL_WIDTH),
        .DEPTH (`DATA_FIFO_DEPTH)
    ) i_data_fifo (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .sync_rst_i (core_rst),
        .wr_i       (data_wr),
        .wr_data_i  (data_word),
        .rd_i       (data_rd),
        .rd_data_o  (data_head),
        .empty_o    (),
        .full_o     (),
        .free_o     (data_free)
    );

    upl_fifo #(
        .WIDTH ($bits(line_info_t)),
        .DEPTH (`CTRL_FIFO_DEPTH)
    ) i_ctrl_fifo (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .sync_rst_i (core_rst),
        .wr_i       (ctrl_wr),
        .wr_data_i  (ctrl_info),
        .rd_i       (ctrl_rd),
        .rd_data_o  (ctrl_head),
        .empty_o    (ctrl_empty),
        .full_o     (ctrl_full),
        .free_o     ()
    );

    upl_sender i_sender (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .core_rst_i   (core_rst),
        .ctrl_empty_i (ctrl_empty),
        .ctrl_info_i  (ctrl_head),
        .data_word_i  (data_head),
        .upl_ack_i    (upl_ack_i),
        .ctrl_rd_o    (ctrl_rd),
        .data_rd_o    (data_rd),
        .upl_req_o    (upl_req_o),
        .upl_en_o     (upl_en_o),
        .upl_data_o   (upl_data_o)
    );

endmodule

`default_nettype wire
